// File: lane_top.f
+incdir+source
source/lane_pkg.sv
source/lane_csr.sv
source/lane_sequencer.sv
source/lane_vrf.sv
source/lane_alu.sv
source/lane_top.sv
sim/lane_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= lane_tb
FILELIST  ?= lane_top.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: sim/lane_tb.sv
// Vector lane testbench

`timescale 1ns/1ps

`include "lane_defs.svh"

module lane_tb import lane_pkg::*; ();

  typedef logic [`LANE_VL_W-1:0] vl_t;

  localparam int Tmo = 200;

  logic     clk_i = 1'b0;
  logic     rst_ni;
  pe_req_t  pe_req_i;
  logic     pe_req_valid_i, pe_req_ready_o;
  pe_resp_t pe_resp_o;
  elen_t    stu_operand_o;
  logic     stu_operand_valid_o;
  logic     stu_operand_ready_i = 1'b1;
  logic     ldu_req_i, ldu_gnt_o;
  vrf_wr_t  ldu_wr_i;
  logic     csr_we_i;
  csr_wr_t  csr_wr_i;
  logic     vxsat_o;
  vxrm_e    vxrm_o;

  // Reference state
  elen_t model_vrf [2 ** `LANE_ADDR_W];
  vxrm_e model_vxrm;
  logic  model_sat;
  elen_t exp_q [$];
  vid_t  exp_id;
  logic  rand_ready = 1'b0;
  int    resp_cnt = 0;
  int    checks = 0;
  int    errors = 0;

  lane_top DUT (.*);

  always #4 clk_i = ~clk_i;

  // Store back-pressure
  always @(posedge clk_i) begin
    stu_operand_ready_i <= rand_ready ? 1'($urandom_range(1, 0)) : 1'b1;
  end

  function automatic int addr_of(int vreg, int idx);
    return vreg * `LANE_VLMAX + idx;
  endfunction

  function automatic void check_equal(string name, elen_t got, elen_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endfunction

  task automatic timeout_fail(string what);
    $display("Timeout at %0t: %s", $time, what);
    $display("Checks: %0d, errors: %0d", checks, errors + 1);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  // Expected element from opcode, operands and rounding mode
  function automatic elen_t lane_ref_op(lane_op_e op, elen_t a, elen_t b);
    logic [`LANE_ELEN:0] v;
    v = {1'b0, a} + {1'b0, b};
    case (op)
      OP_ADD: return a + b;
      OP_SUB: return a - b;
      OP_SADDU: begin
        if (v[`LANE_ELEN]) begin
          model_sat = 1'b1;
          return '1;
        end
        return v[`LANE_ELEN-1:0];
      end
      default: begin
        // Halve the 33-bit sum and round by the mode
        case (model_vxrm)
          RNU: return elen_t'((v + 1'b1) >> 1);
          RNE: return (v[1:0] == 2'b11) ? elen_t'((v + 1'b1) >> 1) : v[`LANE_ELEN:1];
          ROD: return {v[`LANE_ELEN:2], v[1] | v[0]};
          default: return v[`LANE_ELEN:1];
        endcase
      end
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Compare process
  //////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (rst_ni && pe_resp_o.valid) begin
      resp_cnt++;
      check_equal("pe_resp_o.id", elen_t'(pe_resp_o.id), elen_t'(exp_id));
    end
    if (rst_ni && stu_operand_valid_o) begin
      // Lane must stay busy while a store streams
      check_equal("pe_req_ready_o", elen_t'(pe_req_ready_o), 0);
      if (stu_operand_ready_i) begin
        assert (exp_q.size() != 0) else begin
          errors++;
          $display("Store element at %0t arrived with none expected", $time);
        end
        if (exp_q.size() != 0) begin
          check_equal("stu_operand_o", stu_operand_o, exp_q.pop_front());
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Drivers
  //////////////////////////////////////////////////

  task automatic load_write(int addr, elen_t data);
    int t = 0;
    @(posedge clk_i);
    ldu_req_i <= 1'b1;
    ldu_wr_i  <= '{addr: vaddr_t'(addr), data: data};
    @(negedge clk_i);
    while (!ldu_gnt_o) begin
      if (t == Tmo) timeout_fail("load write was never granted");
      t++;
      @(negedge clk_i);
    end
    @(posedge clk_i);
    ldu_req_i <= 1'b0;
    model_vrf[addr] = data;
  endtask

  task automatic fill_reg(int vreg, elen_t base, elen_t mask);
    for (int i = 0; i < `LANE_VLMAX; i++) begin
      load_write(addr_of(vreg, i), base | ($urandom() & mask));
    end
  endtask

  task automatic send_req(lane_op_e op, int vd, int vs1, int vs2, int vl);
    int t = 0;
    int target;
    target = resp_cnt + 1;
    exp_id = exp_id + 1'b1;
    @(posedge clk_i);
    pe_req_i <= '{op: op, id: exp_id, vd: vreg_t'(vd), vs1: vreg_t'(vs1),
                  vs2: vreg_t'(vs2), vl: vl_t'(vl)};
    pe_req_valid_i <= 1'b1;
    @(negedge clk_i);
    while (!pe_req_ready_o) begin
      if (t == Tmo) timeout_fail("request was never accepted");
      t++;
      @(negedge clk_i);
    end
    @(posedge clk_i);
    pe_req_valid_i <= 1'b0;
    t = 0;
    while (resp_cnt < target) begin
      if (t == Tmo) timeout_fail("no response from the lane");
      t++;
      @(posedge clk_i);
    end
    @(posedge clk_i);
    check_equal("response count", resp_cnt, target);
  endtask

  task automatic store_reg(int vreg, int vl);
    for (int i = 0; i < vl; i++) begin
      exp_q.push_back(model_vrf[addr_of(vreg, i)]);
    end
    send_req(OP_STORE, 0, 0, vreg, vl);
    assert (exp_q.size() == 0) else begin
      errors++;
      $display("Store of v%0d ended with %0d elements missing", vreg, exp_q.size());
    end
    exp_q.delete();
  endtask

  // Predict, execute, then read back the whole destination
  task automatic run_op(lane_op_e op, int vd, int vs1, int vs2, int vl);
    for (int i = 0; i < vl; i++) begin
      model_vrf[addr_of(vd, i)] = lane_ref_op(op, model_vrf[addr_of(vs1, i)],
                                              model_vrf[addr_of(vs2, i)]);
    end
    send_req(op, vd, vs1, vs2, vl);
    store_reg(vd, `LANE_VLMAX);
    @(negedge clk_i);
    check_equal("vxsat_o", elen_t'(vxsat_o), elen_t'(model_sat));
  endtask

  task automatic csr_write(vxrm_e mode, logic clr);
    @(posedge clk_i);
    csr_we_i <= 1'b1;
    csr_wr_i <= '{vxrm: mode, clr_sat: clr};
    @(posedge clk_i);
    csr_we_i <= 1'b0;
    model_vxrm = mode;
    if (clr) model_sat = 1'b0;
    @(negedge clk_i);
    check_equal("vxrm_o", elen_t'(vxrm_o), elen_t'(mode));
    check_equal("vxsat_o", elen_t'(vxsat_o), elen_t'(model_sat));
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(87));
    rst_ni         = 1'b0;
    pe_req_i       = '0;
    pe_req_valid_i = 1'b0;
    ldu_req_i      = 1'b0;
    ldu_wr_i       = '0;
    csr_we_i       = 1'b0;
    csr_wr_i       = '0;
    foreach (model_vrf[i]) model_vrf[i] = '0;
    model_vxrm = RNU;
    model_sat  = 1'b0;
    exp_id     = '0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);

    // Reset state
    check_equal("pe_req_ready_o", elen_t'(pe_req_ready_o), 1);
    check_equal("stu_operand_valid_o", elen_t'(stu_operand_valid_o), 0);
    check_equal("vxsat_o", elen_t'(vxsat_o), 0);
    store_reg($urandom_range(7, 0), `LANE_VLMAX);

    // Load fill and read back
    for (int a = 0; a < 2 ** `LANE_ADDR_W; a++) load_write(a, $urandom());
    for (int r = 0; r < `LANE_NR_VREGS; r++) store_reg(r, `LANE_VLMAX);

    // Modulo add and subtract with vl from 0 to 8
    repeat (12) begin
      int vd;
      int len;
      vd  = $urandom_range(7, 0);
      len = $urandom_range(8, 0);
      fork
        run_op($urandom_range(1, 0) ? OP_SUB : OP_ADD, vd,
               $urandom_range(7, 0), $urandom_range(7, 0), len);
        // A load into vd arrives while the writebacks stream
        if (len > 0) begin
          repeat (2) @(posedge clk_i);
          load_write(addr_of(vd, $urandom_range(7, 0)), $urandom());
        end
      join
    end

    // Saturation and sticky flag
    fill_reg(1, 32'hf000_0000, 32'h0000_ffff);
    fill_reg(2, 32'h2000_0000, 32'h0000_ffff);
    run_op(OP_SADDU, 3, 1, 2, `LANE_VLMAX);
    run_op(OP_ADD, 0, 1, 2, `LANE_VLMAX);
    csr_write(RNU, 1'b1);
    fill_reg(4, 32'h0, 32'h0fff_ffff);
    fill_reg(5, 32'h0, 32'h0fff_ffff);
    run_op(OP_SADDU, 6, 4, 5, `LANE_VLMAX);

    // Averaging add in every rounding mode
    for (int m = 0; m < 4; m++) begin
      csr_write(vxrm_e'(m), 1'b0);
      run_op(OP_AADDU, 7, $urandom_range(7, 0), $urandom_range(7, 0), `LANE_VLMAX);
    end

    // Stores under random back-pressure
    rand_ready = 1'b1;
    for (int r = 0; r < `LANE_NR_VREGS; r++) store_reg(r, $urandom_range(8, 1));
    rand_ready = 1'b0;

    repeat (4) @(posedge clk_i);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: source/lane_top.sv
// Vector lane top level

`timescale 1ns/1ps

module lane_top import lane_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  // Main sequencer
  input  pe_req_t  pe_req_i,
  input  logic     pe_req_valid_i,
  output logic     pe_req_ready_o,
  output pe_resp_t pe_resp_o,
  // Store unit
  output elen_t    stu_operand_o,
  output logic     stu_operand_valid_o,
  input  logic     stu_operand_ready_i,
  // Load unit
  input  logic     ldu_req_i,
  input  vrf_wr_t  ldu_wr_i,
  output logic     ldu_gnt_o,
  // Control registers
  input  logic     csr_we_i,
  input  csr_wr_t  csr_wr_i,
  output logic     vxsat_o,
  output vxrm_e    vxrm_o
);

  vaddr_t     rd_addr_a, rd_addr_b;
  elen_t      rd_data_a, rd_data_b;
  logic       issue_valid;
  alu_issue_t issue;
  logic       wb_valid;
  vrf_wr_t    wb;
  logic       sat_set;

  lane_sequencer i_sequencer (
    .clk_i, .rst_ni, .pe_req_i, .pe_req_valid_i, .pe_req_ready_o, .pe_resp_o,
    .rd_addr_a_o  (rd_addr_a),
    .rd_addr_b_o  (rd_addr_b),
    .rd_data_a_i  (rd_data_a),
    .rd_data_b_i  (rd_data_b),
    .issue_valid_o(issue_valid),
    .issue_o      (issue),
    .stu_operand_o, .stu_operand_valid_o, .stu_operand_ready_i
  );

  lane_vrf i_vrf (
    .clk_i, .rst_ni,
    .rd_addr_a_i(rd_addr_a), .rd_addr_b_i(rd_addr_b),
    .rd_data_a_o(rd_data_a), .rd_data_b_o(rd_data_b),
    .wb_valid_i (wb_valid),  .wb_i       (wb),
    .ldu_req_i, .ldu_wr_i, .ldu_gnt_o
  );

  lane_alu i_alu (
    .clk_i, .rst_ni,
    .issue_valid_i(issue_valid), .issue_i(issue), .vxrm_i(vxrm_o),
    .wb_valid_o   (wb_valid),    .wb_o   (wb),    .sat_set_o(sat_set)
  );

  lane_csr i_csr (
    .clk_i, .rst_ni, .csr_we_i, .csr_wr_i,
    .sat_set_i(sat_set), .vxrm_o, .vxsat_o
  );

endmodule

// File: source/lane_alu.sv
// Lane integer ALU

`timescale 1ns/1ps

`include "lane_defs.svh"

module lane_alu import lane_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  // Issue from the sequencer
  input  logic       issue_valid_i,
  input  alu_issue_t issue_i,
  // Rounding mode from the CSR block
  input  vxrm_e      vxrm_i,
  // Writeback to the VRF
  output logic       wb_valid_o,
  output vrf_wr_t    wb_o,
  output logic       sat_set_o
);

  logic [`LANE_ELEN:0] sum_ext;
  elen_t               avg;
  elen_t               res;
  logic                sat;
  logic                wb_valid_q;
  logic                sat_q;
  vrf_wr_t             wb_q;

  // Unsigned sum with the carry kept
  assign sum_ext = {1'b0, issue_i.a} + {1'b0, issue_i.b};

  //////////////////////////////////////////////////
  // Averaging add rounding
  //////////////////////////////////////////////////

  always_comb begin
    avg = sum_ext[`LANE_ELEN:1];
    case (vxrm_i)
      RNU: avg = avg + elen_t'(sum_ext[0]);
      // Ties go to even
      RNE: avg = avg + elen_t'(sum_ext[0] & sum_ext[1]);
      // Jam the shifted-out bit
      ROD: avg[0] = avg[0] | sum_ext[0];
      // RDN truncates
      default: avg = sum_ext[`LANE_ELEN:1];
    endcase
  end

  //////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////

  always_comb begin
    res = '0;
    sat = 1'b0;
    case (issue_i.op)
      OP_ADD: res = issue_i.a + issue_i.b;
      OP_SUB: res = issue_i.a - issue_i.b;
      OP_SADDU: begin
        if (sum_ext[`LANE_ELEN]) begin
          res = '1;
          sat = 1'b1;
        end else begin
          res = sum_ext[`LANE_ELEN-1:0];
        end
      end
      OP_AADDU: res = avg;
      default: res = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_valid_q <= 1'b0;
      sat_q      <= 1'b0;
    end else begin
      wb_valid_q <= issue_valid_i;
      sat_q      <= issue_valid_i & sat;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_valid_i) begin
      wb_q.addr <= issue_i.addr;
      wb_q.data <= res;
    end
  end

  assign wb_valid_o = wb_valid_q;
  assign wb_o       = wb_q;
  assign sat_set_o  = sat_q;

endmodule

// File: source/lane_vrf.sv
// Lane vector register file

`timescale 1ns/1ps

module lane_vrf import lane_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  // Operand reads from the sequencer
  input  vaddr_t  rd_addr_a_i,
  input  vaddr_t  rd_addr_b_i,
  output elen_t   rd_data_a_o,
  output elen_t   rd_data_b_o,
  // ALU writeback
  input  logic    wb_valid_i,
  input  vrf_wr_t wb_i,
  // Load unit writes
  input  logic    ldu_req_i,
  input  vrf_wr_t ldu_wr_i,
  output logic    ldu_gnt_o
);

  localparam int unsigned Depth = 2 ** $bits(vaddr_t);

  elen_t   mem_q [Depth];
  logic    wr_en;
  vrf_wr_t wr;

  //////////////////////////////////////////////////
  // Write arbitration
  //////////////////////////////////////////////////

  // ALU results never wait, loads take the idle slots
  assign ldu_gnt_o = ldu_req_i & ~wb_valid_i;
  assign wr_en     = wb_valid_i | ldu_req_i;
  assign wr        = wb_valid_i ? wb_i : ldu_wr_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < Depth; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_en) begin
      mem_q[wr.addr] <= wr.data;
    end
  end

  //////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////

  // Combinational, no bypass of same-cycle writes
  assign rd_data_a_o = mem_q[rd_addr_a_i];
  assign rd_data_b_o = mem_q[rd_addr_b_i];

endmodule

// File: source/lane_sequencer.sv
// Lane instruction sequencer

`timescale 1ns/1ps

`include "lane_defs.svh"

module lane_sequencer import lane_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  // Main sequencer
  input  pe_req_t    pe_req_i,
  input  logic       pe_req_valid_i,
  output logic       pe_req_ready_o,
  output pe_resp_t   pe_resp_o,
  // VRF read ports
  output vaddr_t     rd_addr_a_o,
  output vaddr_t     rd_addr_b_o,
  input  elen_t      rd_data_a_i,
  input  elen_t      rd_data_b_i,
  // ALU issue
  output logic       issue_valid_o,
  output alu_issue_t issue_o,
  // Store unit
  output elen_t      stu_operand_o,
  output logic       stu_operand_valid_o,
  input  logic       stu_operand_ready_i
);

  seq_state_e            state_q, state_d;
  pe_req_t               req_q;
  logic [`LANE_VL_W-1:0] cnt_q, cnt_d;
  pe_resp_t              resp_q, resp_d;
  logic                  req_hs, in_exec, is_store, last_elem, advance;

  // Flat element address inside the register file
  function automatic vaddr_t elem_addr(vreg_t vreg, logic [`LANE_VL_W-1:0] idx);
    return vaddr_t'(vreg * `LANE_VLMAX + idx);
  endfunction

  assign pe_req_ready_o = (state_q == SEQ_IDLE);
  assign req_hs         = pe_req_valid_i & pe_req_ready_o;
  assign in_exec        = (state_q == SEQ_EXEC);
  assign is_store       = (req_q.op == OP_STORE);
  assign last_elem      = (cnt_q == req_q.vl - 1'b1);

  assign rd_addr_a_o = elem_addr(req_q.vs1, cnt_q);
  assign rd_addr_b_o = elem_addr(req_q.vs2, cnt_q);

  //////////////////////////////////////////////////
  // Element dispatch
  //////////////////////////////////////////////////

  assign issue_valid_o = in_exec & ~is_store;
  assign issue_o.op    = req_q.op;
  assign issue_o.a     = rd_data_a_i;
  assign issue_o.b     = rd_data_b_i;
  assign issue_o.addr  = elem_addr(req_q.vd, cnt_q);

  // Stores stream operand b, held until the handshake
  assign stu_operand_o       = rd_data_b_i;
  assign stu_operand_valid_o = in_exec & is_store;

  assign advance = in_exec & (~is_store | stu_operand_ready_i);

  always_comb begin
    state_d      = state_q;
    cnt_d        = cnt_q;
    resp_d.valid = 1'b0;
    resp_d.id    = req_q.id;
    case (state_q)
      SEQ_IDLE: begin
        if (req_hs) begin
          cnt_d = '0;
          if (pe_req_i.vl == '0) begin
            resp_d.valid = 1'b1;
            resp_d.id    = pe_req_i.id;
          end else begin
            state_d = SEQ_EXEC;
          end
        end
      end
      SEQ_EXEC: begin
        if (advance) begin
          cnt_d = cnt_q + 1'b1;
          if (last_elem) begin
            // Stores finish at the last handshake
            if (is_store) begin
              resp_d.valid = 1'b1;
              state_d      = SEQ_IDLE;
            end else begin
              state_d = SEQ_DRAIN;
            end
          end
        end
      end
      // Last writeback is in flight this cycle
      SEQ_DRAIN: begin
        resp_d.valid = 1'b1;
        state_d      = SEQ_IDLE;
      end
      default: state_d = SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SEQ_IDLE;
      cnt_q   <= '0;
      resp_q  <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      resp_q  <= resp_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_hs) begin
      req_q <= pe_req_i;
    end
  end

  assign pe_resp_o = resp_q;

endmodule

// File: source/lane_csr.sv
// Lane control registers

`timescale 1ns/1ps

module lane_csr import lane_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  // Write strobe from the control side
  input  logic    csr_we_i,
  input  csr_wr_t csr_wr_i,
  // Saturation events from the ALU
  input  logic    sat_set_i,
  output vxrm_e   vxrm_o,
  output logic    vxsat_o
);

  vxrm_e vxrm_q;
  logic  vxsat_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vxrm_q  <= RNU;
      vxsat_q <= 1'b0;
    end else begin
      if (csr_we_i) begin
        vxrm_q <= csr_wr_i.vxrm;
      end
      // Sticky flag, a new saturation beats a clear
      if (sat_set_i) begin
        vxsat_q <= 1'b1;
      end else if (csr_we_i && csr_wr_i.clr_sat) begin
        vxsat_q <= 1'b0;
      end
    end
  end

  assign vxrm_o  = vxrm_q;
  assign vxsat_o = vxsat_q;

endmodule

// File: source/lane_pkg.sv
// Vector lane types

`include "lane_defs.svh"

package lane_pkg;

  typedef logic [`LANE_ELEN-1:0]              elen_t;
  typedef logic [`LANE_ADDR_W-1:0]            vaddr_t;
  typedef logic [$clog2(`LANE_NR_VREGS)-1:0]  vreg_t;
  typedef logic [1:0]                         vid_t;

  // Fixed-point rounding modes
  typedef enum logic [1:0] {RNU, RNE, RDN, ROD} vxrm_e;

  typedef enum logic [2:0] {OP_ADD, OP_SUB, OP_SADDU, OP_AADDU, OP_STORE} lane_op_e;

  typedef enum logic [1:0] {SEQ_IDLE, SEQ_EXEC, SEQ_DRAIN} seq_state_e;

  // Request from the main sequencer
  typedef struct packed {
    lane_op_e               op;
    vid_t                   id;
    vreg_t                  vd;
    vreg_t                  vs1;
    vreg_t                  vs2;
    logic [`LANE_VL_W-1:0]  vl;
  } pe_req_t;

  typedef struct packed {
    logic valid;
    vid_t id;
  } pe_resp_t;

  // One element handed to the ALU
  typedef struct packed {
    lane_op_e op;
    elen_t    a;
    elen_t    b;
    vaddr_t   addr;
  } alu_issue_t;

  typedef struct packed {
    vaddr_t addr;
    elen_t  data;
  } vrf_wr_t;

  typedef struct packed {
    vxrm_e vxrm;
    logic  clr_sat;
  } csr_wr_t;

endpackage

// File: source/lane_defs.svh
// Vector lane sizing macros

`ifndef LANE_DEFS_SVH
`define LANE_DEFS_SVH

//////////////////////////////////////////////////
// Datapath
//////////////////////////////////////////////////

// Element width in bits
`define LANE_ELEN     32

//////////////////////////////////////////////////
// Register file geometry
//////////////////////////////////////////////////

`define LANE_NR_VREGS 8
// Elements held per vector register
`define LANE_VLMAX    8
// Element address is vreg * VLMAX + element index
`define LANE_ADDR_W   6
// Wide enough for vl = VLMAX
`define LANE_VL_W     4

`endif
